/* hdl/csr_pkg.sv */
`default_nettype none

package csr_pkg;

  ////////////////////
  // types
  ////////////////////

  // one machine word
  typedef logic [31:0] xlen_t;

  // csr address space is 12 bits wide
  typedef logic [11:0] csr_addr_t;

  // integer register index
  typedef logic [4:0] reg_addr_t;

  // how a csr instruction modifies its target
  typedef logic [1:0] csr_wtype_t;

  // exception code, interrupts are not modelled
  typedef logic [3:0] cause_t;

  ////////////////////
  // write kinds
  ////////////////////

  localparam csr_wtype_t CSR_WRITE_NONE           = 2'd0;
  localparam csr_wtype_t CSR_WRITE_RAW_VALUE      = 2'd1;
  localparam csr_wtype_t CSR_WRITE_SET_BIT_MASK   = 2'd2;
  localparam csr_wtype_t CSR_WRITE_CLEAR_BIT_MASK = 2'd3;

  ////////////////////
  // csr addresses
  ////////////////////

  localparam csr_addr_t CSR_ADDR_MTVEC     = 12'h305;
  localparam csr_addr_t CSR_ADDR_MSCRATCH  = 12'h340;
  localparam csr_addr_t CSR_ADDR_MEPC      = 12'h341;
  localparam csr_addr_t CSR_ADDR_MCAUSE    = 12'h342;
  localparam csr_addr_t CSR_ADDR_MTVAL     = 12'h343;
  localparam csr_addr_t CSR_ADDR_MCYCLE    = 12'hB00;
  localparam csr_addr_t CSR_ADDR_MINSTRET  = 12'hB02;
  localparam csr_addr_t CSR_ADDR_MCYCLEH   = 12'hB80;
  localparam csr_addr_t CSR_ADDR_MINSTRETH = 12'hB82;

  // trap causes
  localparam cause_t CAUSE_ILLEGAL_INSN = 4'd2;

  // instruction fields
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;
  localparam logic [2:0] FUNCT3_CSRRW  = 3'b001;
  localparam logic [2:0] FUNCT3_CSRRS  = 3'b010;
  localparam logic [2:0] FUNCT3_CSRRC  = 3'b011;
  localparam logic [2:0] FUNCT3_CSRRWI = 3'b101;
  localparam logic [2:0] FUNCT3_CSRRSI = 3'b110;
  localparam logic [2:0] FUNCT3_CSRRCI = 3'b111;

endpackage

`default_nettype wire

/* hdl/csr_decode.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_decode (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wire                  in_valid_i,
  output logic                 in_ready_o,
  input  wire csr_pkg::xlen_t  in_pc_i,
  input  wire csr_pkg::xlen_t  in_insn_i,
  input  wire csr_pkg::xlen_t  in_rs1_data_i,
  input  wire                  in_trap_i,
  input  wire csr_pkg::cause_t in_cause_i,
  input  wire csr_pkg::xlen_t  in_tval_i,
  input  wire                  d_ready_i,
  output logic                 d_valid_o,
  output csr_pkg::xlen_t       d_pc_o,
  output csr_pkg::reg_addr_t   d_rd_addr_o,
  output csr_pkg::csr_addr_t   d_csr_addr_o,
  output csr_pkg::csr_wtype_t  d_wtype_o,
  output csr_pkg::xlen_t       d_operand_o,
  output logic                 d_trap_o,
  output csr_pkg::cause_t      d_cause_o,
  output csr_pkg::xlen_t       d_tval_o
);

  logic [6:0]          opcode;
  logic [2:0]          funct3;
  csr_pkg::reg_addr_t  rd_field;
  csr_pkg::reg_addr_t  rs1_field;
  csr_pkg::csr_addr_t  csr_field;
  logic                is_csr;
  logic                csr_known;
  logic                illegal;
  logic                accept;
  logic                trap_n;
  csr_pkg::cause_t     cause_n;
  csr_pkg::xlen_t      tval_n;
  csr_pkg::csr_wtype_t wtype_n;
  csr_pkg::xlen_t      operand_n;

  // instruction fields
  assign opcode    = in_insn_i[6:0];
  assign rd_field  = in_insn_i[11:7];
  assign funct3    = in_insn_i[14:12];
  assign rs1_field = in_insn_i[19:15];
  assign csr_field = in_insn_i[31:20];

  ////////////////////
  // decode
  ////////////////////

  // only the six zicsr forms count, ecall/ebreak and friends do not
  always_comb begin
    is_csr = 1'b0;
    if (opcode == csr_pkg::OPCODE_SYSTEM) begin
      case (funct3)
        csr_pkg::FUNCT3_CSRRW, csr_pkg::FUNCT3_CSRRS, csr_pkg::FUNCT3_CSRRC,
        csr_pkg::FUNCT3_CSRRWI, csr_pkg::FUNCT3_CSRRSI, csr_pkg::FUNCT3_CSRRCI:
          is_csr = 1'b1;
        default: is_csr = 1'b0;
      endcase
    end
  end

  always_comb begin
    case (csr_field)
      csr_pkg::CSR_ADDR_MTVEC, csr_pkg::CSR_ADDR_MSCRATCH, csr_pkg::CSR_ADDR_MEPC,
      csr_pkg::CSR_ADDR_MCAUSE, csr_pkg::CSR_ADDR_MTVAL, csr_pkg::CSR_ADDR_MCYCLE,
      csr_pkg::CSR_ADDR_MCYCLEH, csr_pkg::CSR_ADDR_MINSTRET, csr_pkg::CSR_ADDR_MINSTRETH:
        csr_known = 1'b1;
      default: csr_known = 1'b0;
    endcase
  end

  assign illegal = is_csr && !csr_known;

  // upstream trap wins over our own illegal-instruction trap
  assign trap_n  = in_trap_i || illegal;
  assign cause_n = in_trap_i ? in_cause_i :
                   (illegal ? csr_pkg::CAUSE_ILLEGAL_INSN : '0);
  assign tval_n  = in_trap_i ? in_tval_i : (illegal ? in_insn_i : '0);

  // set/clear with rs1 = x0 (or uimm = 0) is a pure read
  always_comb begin
    case (funct3)
      csr_pkg::FUNCT3_CSRRW, csr_pkg::FUNCT3_CSRRWI:
        wtype_n = csr_pkg::CSR_WRITE_RAW_VALUE;
      csr_pkg::FUNCT3_CSRRS, csr_pkg::FUNCT3_CSRRSI:
        wtype_n = (rs1_field != '0) ? csr_pkg::CSR_WRITE_SET_BIT_MASK : csr_pkg::CSR_WRITE_NONE;
      csr_pkg::FUNCT3_CSRRC, csr_pkg::FUNCT3_CSRRCI:
        wtype_n = (rs1_field != '0) ? csr_pkg::CSR_WRITE_CLEAR_BIT_MASK : csr_pkg::CSR_WRITE_NONE;
      default: wtype_n = csr_pkg::CSR_WRITE_NONE;
    endcase
    if (!is_csr || trap_n)
      wtype_n = csr_pkg::CSR_WRITE_NONE;
  end

  // funct3[2] selects the zero-extended uimm form
  assign operand_n = !is_csr  ? '0 :
                     funct3[2] ? {27'd0, rs1_field} : in_rs1_data_i;

  ////////////////////
  // pipeline register
  ////////////////////

  assign in_ready_o = !d_valid_o || d_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      d_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      d_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      d_pc_o       <= in_pc_i;
      d_rd_addr_o  <= is_csr ? rd_field : '0;
      d_csr_addr_o <= is_csr ? csr_field : '0;
      d_wtype_o    <= wtype_n;
      d_operand_o  <= operand_n;
      d_trap_o     <= trap_n;
      d_cause_o    <= cause_n;
      d_tval_o     <= tval_n;
    end
  end

  // a stalled item must not change under the register file
  a_hold_stalled: assert property (@(posedge clk_i) disable iff (rst_i)
    d_valid_o && !d_ready_i |=> d_valid_o && $stable(d_pc_o) && $stable(d_csr_addr_o)
      && $stable(d_wtype_o) && $stable(d_operand_o) && $stable(d_trap_o));

endmodule

`default_nettype wire

/* hdl/csr_regfile.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_regfile (
  input  wire                      clk_i,
  input  wire                      rst_i,
  input  wire                      d_valid_i,
  input  wire                      d_ready_i,
  input  wire csr_pkg::xlen_t      d_pc_i,
  input  wire csr_pkg::reg_addr_t  d_rd_addr_i,
  input  wire csr_pkg::csr_addr_t  d_csr_addr_i,
  input  wire csr_pkg::csr_wtype_t d_wtype_i,
  input  wire csr_pkg::xlen_t      d_operand_i,
  input  wire                      d_trap_i,
  input  wire csr_pkg::cause_t     d_cause_i,
  input  wire csr_pkg::xlen_t      d_tval_i,
  output csr_pkg::xlen_t           csr_rdata_o,
  output csr_pkg::xlen_t           csr_wdata_o,
  output csr_pkg::xlen_t           csr_rmask_o,
  output csr_pkg::xlen_t           csr_wmask_o,
  output csr_pkg::xlen_t           redirect_pc_o
);

  csr_pkg::xlen_t mtvec_q;
  csr_pkg::xlen_t mscratch_q;
  csr_pkg::xlen_t mepc_q;
  csr_pkg::xlen_t mcause_q;
  csr_pkg::xlen_t mtval_q;
  logic [63:0]    mcycle_q;
  logic [63:0]    minstret_q;
  csr_pkg::xlen_t rdata;
  csr_pkg::xlen_t wdata;
  logic           commit;

  // the instruction leaves the decode register this cycle
  assign commit = d_valid_i && d_ready_i;

  ////////////////////
  // read and modify
  ////////////////////

  always_comb begin
    case (d_csr_addr_i)
      csr_pkg::CSR_ADDR_MTVEC:     rdata = mtvec_q;
      csr_pkg::CSR_ADDR_MSCRATCH:  rdata = mscratch_q;
      csr_pkg::CSR_ADDR_MEPC:      rdata = mepc_q;
      csr_pkg::CSR_ADDR_MCAUSE:    rdata = mcause_q;
      csr_pkg::CSR_ADDR_MTVAL:     rdata = mtval_q;
      csr_pkg::CSR_ADDR_MCYCLE:    rdata = mcycle_q[31:0];
      csr_pkg::CSR_ADDR_MCYCLEH:   rdata = mcycle_q[63:32];
      csr_pkg::CSR_ADDR_MINSTRET:  rdata = minstret_q[31:0];
      csr_pkg::CSR_ADDR_MINSTRETH: rdata = minstret_q[63:32];
      default:                     rdata = '0;
    endcase
  end

  always_comb begin
    case (d_wtype_i)
      csr_pkg::CSR_WRITE_RAW_VALUE:      wdata = d_operand_i;
      csr_pkg::CSR_WRITE_SET_BIT_MASK:   wdata = rdata | d_operand_i;
      csr_pkg::CSR_WRITE_CLEAR_BIT_MASK: wdata = rdata & ~d_operand_i;
      default:                           wdata = '0;
    endcase
  end

  // rd = x0 means the old value is never looked at
  assign csr_rmask_o = (d_rd_addr_i != '0) ? 32'hffff_ffff : '0;
  assign csr_wmask_o = (d_wtype_i != csr_pkg::CSR_WRITE_NONE) ? 32'hffff_ffff : '0;
  assign csr_rdata_o = rdata;
  assign csr_wdata_o = wdata;

  // trap vector, direct mode only
  assign redirect_pc_o = {mtvec_q[31:2], 2'b00};

  ////////////////////
  // state update
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
    end else if (commit) begin
      if (d_trap_i) begin
        // trap entry touches only the three trap registers
        mepc_q   <= d_pc_i;
        mcause_q <= {28'd0, d_cause_i};
        mtval_q  <= d_tval_i;
      end else if (d_wtype_i != csr_pkg::CSR_WRITE_NONE) begin
        case (d_csr_addr_i)
          csr_pkg::CSR_ADDR_MTVEC:    mtvec_q    <= {wdata[31:2], 2'b00};
          csr_pkg::CSR_ADDR_MSCRATCH: mscratch_q <= wdata;
          csr_pkg::CSR_ADDR_MEPC:     mepc_q     <= wdata;
          csr_pkg::CSR_ADDR_MCAUSE:   mcause_q   <= wdata;
          csr_pkg::CSR_ADDR_MTVAL:    mtval_q    <= wdata;
          // counters are read-only here
          default: ;
        endcase
      end
    end
  end

  // free-running cycle counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      mcycle_q <= '0;
    end else begin
      mcycle_q <= mcycle_q + 64'd1;
    end
  end

  // counts commits, so a read sees only older instructions
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      minstret_q <= '0;
    end else if (commit) begin
      minstret_q <= minstret_q + 64'd1;
    end
  end

  // the trap target stays word aligned whatever software writes
  a_mtvec_aligned: assert property (@(posedge clk_i) disable iff (rst_i)
    mtvec_q[1:0] == 2'b00);

endmodule

`default_nettype wire

/* hdl/csr_retire.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_retire (
  input  wire                     clk_i,
  input  wire                     rst_i,
  input  wire                     d_valid_i,
  output logic                    d_ready_o,
  input  wire csr_pkg::xlen_t     d_pc_i,
  input  wire csr_pkg::reg_addr_t d_rd_addr_i,
  input  wire csr_pkg::csr_addr_t d_csr_addr_i,
  input  wire                     d_trap_i,
  input  wire csr_pkg::cause_t    d_cause_i,
  input  wire csr_pkg::xlen_t     csr_rdata_i,
  input  wire csr_pkg::xlen_t     csr_wdata_i,
  input  wire csr_pkg::xlen_t     csr_rmask_i,
  input  wire csr_pkg::xlen_t     csr_wmask_i,
  input  wire csr_pkg::xlen_t     redirect_pc_i,
  input  wire                     out_ready_i,
  output logic                    out_valid_o,
  output csr_pkg::xlen_t          out_pc_o,
  output csr_pkg::reg_addr_t      out_rd_addr_o,
  output csr_pkg::xlen_t          out_rd_data_o,
  output logic                    out_rd_we_o,
  output csr_pkg::csr_addr_t      out_csr_addr_o,
  output csr_pkg::xlen_t          out_csr_rmask_o,
  output csr_pkg::xlen_t          out_csr_wmask_o,
  output csr_pkg::xlen_t          out_csr_rdata_o,
  output csr_pkg::xlen_t          out_csr_wdata_o,
  output logic                    out_trap_o,
  output csr_pkg::cause_t         out_cause_o,
  output csr_pkg::xlen_t          out_redirect_pc_o
);

  logic load;

  // room when empty or when the current record leaves this cycle
  assign d_ready_o = !out_valid_o || out_ready_i;
  assign load      = d_valid_i && d_ready_o;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (d_ready_o) begin
      out_valid_o <= d_valid_i;
    end
  end

  ////////////////////
  // record payload
  ////////////////////

  always_ff @(posedge clk_i) begin
    if (load) begin
      out_pc_o          <= d_pc_i;
      out_rd_addr_o     <= d_rd_addr_i;
      out_rd_data_o     <= csr_rdata_i;
      // a trapping instruction never writes rd
      out_rd_we_o       <= (csr_rmask_i != '0) && !d_trap_i;
      out_csr_addr_o    <= d_csr_addr_i;
      out_csr_rmask_o   <= csr_rmask_i;
      out_csr_wmask_o   <= csr_wmask_i;
      out_csr_rdata_o   <= csr_rdata_i;
      out_csr_wdata_o   <= csr_wdata_i;
      out_trap_o        <= d_trap_i;
      out_cause_o       <= d_cause_i;
      out_redirect_pc_o <= d_trap_i ? redirect_pc_i : '0;
    end
  end

  a_out_stable: assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pc_o)
      && $stable(out_rd_data_o) && $stable(out_csr_wdata_o) && $stable(out_trap_o));

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_unit (
  input  wire                  clk_i,
  input  wire                  rst_i,
  // retiring instructions in
  input  wire                  in_valid_i,
  output logic                 in_ready_o,
  input  wire csr_pkg::xlen_t  in_pc_i,
  input  wire csr_pkg::xlen_t  in_insn_i,
  input  wire csr_pkg::xlen_t  in_rs1_data_i,
  input  wire                  in_trap_i,
  input  wire csr_pkg::cause_t in_cause_i,
  input  wire csr_pkg::xlen_t  in_tval_i,
  // retirement records out
  output logic                 out_valid_o,
  input  wire                  out_ready_i,
  output csr_pkg::xlen_t       out_pc_o,
  output csr_pkg::reg_addr_t   out_rd_addr_o,
  output csr_pkg::xlen_t       out_rd_data_o,
  output logic                 out_rd_we_o,
  output csr_pkg::csr_addr_t   out_csr_addr_o,
  output csr_pkg::xlen_t       out_csr_rmask_o,
  output csr_pkg::xlen_t       out_csr_wmask_o,
  output csr_pkg::xlen_t       out_csr_rdata_o,
  output csr_pkg::xlen_t       out_csr_wdata_o,
  output logic                 out_trap_o,
  output csr_pkg::cause_t      out_cause_o,
  output csr_pkg::xlen_t       out_redirect_pc_o
);

  // decode stage outputs
  logic                d_valid;
  logic                d_ready;
  csr_pkg::xlen_t      d_pc;
  csr_pkg::reg_addr_t  d_rd_addr;
  csr_pkg::csr_addr_t  d_csr_addr;
  csr_pkg::csr_wtype_t d_wtype;
  csr_pkg::xlen_t      d_operand;
  logic                d_trap;
  csr_pkg::cause_t     d_cause;
  csr_pkg::xlen_t      d_tval;

  // fields computed by the register file
  csr_pkg::xlen_t csr_rdata;
  csr_pkg::xlen_t csr_wdata;
  csr_pkg::xlen_t csr_rmask;
  csr_pkg::xlen_t csr_wmask;
  csr_pkg::xlen_t redirect_pc;

  csr_decode u_decode (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .in_pc_i       (in_pc_i),
    .in_insn_i     (in_insn_i),
    .in_rs1_data_i (in_rs1_data_i),
    .in_trap_i     (in_trap_i),
    .in_cause_i    (in_cause_i),
    .in_tval_i     (in_tval_i),
    .d_ready_i     (d_ready),
    .d_valid_o     (d_valid),
    .d_pc_o        (d_pc),
    .d_rd_addr_o   (d_rd_addr),
    .d_csr_addr_o  (d_csr_addr),
    .d_wtype_o     (d_wtype),
    .d_operand_o   (d_operand),
    .d_trap_o      (d_trap),
    .d_cause_o     (d_cause),
    .d_tval_o      (d_tval)
  );

  csr_regfile u_regfile (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .d_valid_i     (d_valid),
    .d_ready_i     (d_ready),
    .d_pc_i        (d_pc),
    .d_rd_addr_i   (d_rd_addr),
    .d_csr_addr_i  (d_csr_addr),
    .d_wtype_i     (d_wtype),
    .d_operand_i   (d_operand),
    .d_trap_i      (d_trap),
    .d_cause_i     (d_cause),
    .d_tval_i      (d_tval),
    .csr_rdata_o   (csr_rdata),
    .csr_wdata_o   (csr_wdata),
    .csr_rmask_o   (csr_rmask),
    .csr_wmask_o   (csr_wmask),
    .redirect_pc_o (redirect_pc)
  );

  csr_retire u_retire (
    .clk_i             (clk_i),
    .rst_i             (rst_i),
    .d_valid_i         (d_valid),
    .d_ready_o         (d_ready),
    .d_pc_i            (d_pc),
    .d_rd_addr_i       (d_rd_addr),
    .d_csr_addr_i      (d_csr_addr),
    .d_trap_i          (d_trap),
    .d_cause_i         (d_cause),
    .csr_rdata_i       (csr_rdata),
    .csr_wdata_i       (csr_wdata),
    .csr_rmask_i       (csr_rmask),
    .csr_wmask_i       (csr_wmask),
    .redirect_pc_i     (redirect_pc),
    .out_ready_i       (out_ready_i),
    .out_valid_o       (out_valid_o),
    .out_pc_o          (out_pc_o),
    .out_rd_addr_o     (out_rd_addr_o),
    .out_rd_data_o     (out_rd_data_o),
    .out_rd_we_o       (out_rd_we_o),
    .out_csr_addr_o    (out_csr_addr_o),
    .out_csr_rmask_o   (out_csr_rmask_o),
    .out_csr_wmask_o   (out_csr_wmask_o),
    .out_csr_rdata_o   (out_csr_rdata_o),
    .out_csr_wdata_o   (out_csr_wdata_o),
    .out_trap_o        (out_trap_o),
    .out_cause_o       (out_cause_o),
    .out_redirect_pc_o (out_redirect_pc_o)
  );

endmodule

`default_nettype wire

/* tests/csr_model.svh */
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// one retirement record, as predicted or as seen on the output stream
typedef struct packed {
  csr_pkg::xlen_t      pc;
  csr_pkg::reg_addr_t  rd_addr;
  csr_pkg::xlen_t      rd_data;
  logic                rd_we;
  csr_pkg::csr_addr_t  csr_addr;
  csr_pkg::xlen_t      rmask;
  csr_pkg::xlen_t      wmask;
  csr_pkg::xlen_t      rdata;
  csr_pkg::xlen_t      wdata;
  logic                trap;
  csr_pkg::cause_t     cause;
  csr_pkg::xlen_t      redirect;
  // model side only, needed to finish an mcycle record
  csr_pkg::csr_wtype_t wtype;
  csr_pkg::xlen_t      operand;
} record_t;

// architectural state as the model sees it
csr_pkg::xlen_t m_mtvec = '0;
csr_pkg::xlen_t m_mscratch = '0;
csr_pkg::xlen_t m_mepc = '0;
csr_pkg::xlen_t m_mcause = '0;
csr_pkg::xlen_t m_mtval = '0;
logic [63:0]    m_minstret = '0;

function automatic logic [31:0] xorshift32(input logic [31:0] s);
  logic [31:0] x;
  x = s;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  return x;
endfunction

// mcycle low is not predicted, its high half stays zero in a short run
function automatic csr_pkg::xlen_t model_read(input csr_pkg::csr_addr_t addr);
  case (addr)
    csr_pkg::CSR_ADDR_MTVEC:     return m_mtvec;
    csr_pkg::CSR_ADDR_MSCRATCH:  return m_mscratch;
    csr_pkg::CSR_ADDR_MEPC:      return m_mepc;
    csr_pkg::CSR_ADDR_MCAUSE:    return m_mcause;
    csr_pkg::CSR_ADDR_MTVAL:     return m_mtval;
    csr_pkg::CSR_ADDR_MINSTRET:  return m_minstret[31:0];
    csr_pkg::CSR_ADDR_MINSTRETH: return m_minstret[63:32];
    default:                     return '0;
  endcase
endfunction

function automatic csr_pkg::xlen_t model_modify(input csr_pkg::csr_wtype_t wtype,
                                                input csr_pkg::xlen_t old,
                                                input csr_pkg::xlen_t operand);
  case (wtype)
    csr_pkg::CSR_WRITE_RAW_VALUE:      return operand;
    csr_pkg::CSR_WRITE_SET_BIT_MASK:   return old | operand;
    csr_pkg::CSR_WRITE_CLEAR_BIT_MASK: return old & ~operand;
    default:                           return '0;
  endcase
endfunction

// predicts the record of one accepted instruction and commits its effect
function automatic record_t model_retire(input csr_pkg::xlen_t pc, input csr_pkg::xlen_t insn,
                                         input csr_pkg::xlen_t rs1_data, input logic up_trap,
                                         input csr_pkg::cause_t up_cause,
                                         input csr_pkg::xlen_t up_tval);
  record_t        r;
  logic [2:0]     f3;
  logic [4:0]     rs1f;
  logic           is_csr;
  logic           known;
  csr_pkg::xlen_t tval;
  r      = '0;
  f3     = insn[14:12];
  rs1f   = insn[19:15];
  is_csr = (insn[6:0] == csr_pkg::OPCODE_SYSTEM) && (f3[1:0] != 2'b00);
  known  = insn[31:20] inside {csr_pkg::CSR_ADDR_MTVEC, csr_pkg::CSR_ADDR_MSCRATCH,
    csr_pkg::CSR_ADDR_MEPC, csr_pkg::CSR_ADDR_MCAUSE, csr_pkg::CSR_ADDR_MTVAL,
    csr_pkg::CSR_ADDR_MCYCLE, csr_pkg::CSR_ADDR_MCYCLEH, csr_pkg::CSR_ADDR_MINSTRET,
    csr_pkg::CSR_ADDR_MINSTRETH};
  r.pc    = pc;
  r.trap  = up_trap || (is_csr && !known);
  r.cause = up_trap ? up_cause : (r.trap ? csr_pkg::CAUSE_ILLEGAL_INSN : '0);
  tval    = up_trap ? up_tval : (r.trap ? insn : '0);
  if (is_csr) begin
    r.rd_addr  = insn[11:7];
    r.csr_addr = insn[31:20];
    r.operand  = f3[2] ? {27'd0, rs1f} : rs1_data;
    if (!r.trap && f3[1:0] == 2'b01)
      r.wtype = csr_pkg::CSR_WRITE_RAW_VALUE;
    else if (!r.trap && rs1f != '0)
      r.wtype = (f3[1:0] == 2'b10) ? csr_pkg::CSR_WRITE_SET_BIT_MASK
                                   : csr_pkg::CSR_WRITE_CLEAR_BIT_MASK;
  end
  r.rdata    = model_read(r.csr_addr);
  r.rd_data  = r.rdata;
  r.rmask    = (r.rd_addr != '0) ? 32'hffff_ffff : 32'h0;
  r.wmask    = (r.wtype != csr_pkg::CSR_WRITE_NONE) ? 32'hffff_ffff : 32'h0;
  r.wdata    = model_modify(r.wtype, r.rdata, r.operand);
  r.rd_we    = (r.rd_addr != '0) && !r.trap;
  r.redirect = r.trap ? {m_mtvec[31:2], 2'b00} : '0;
  if (r.trap) begin
    m_mepc   = pc;
    m_mcause = {28'd0, r.cause};
    m_mtval  = tval;
  end else if (r.wtype != csr_pkg::CSR_WRITE_NONE) begin
    case (r.csr_addr)
      csr_pkg::CSR_ADDR_MTVEC:    m_mtvec = {r.wdata[31:2], 2'b00};
      csr_pkg::CSR_ADDR_MSCRATCH: m_mscratch = r.wdata;
      csr_pkg::CSR_ADDR_MEPC:     m_mepc = r.wdata;
      csr_pkg::CSR_ADDR_MCAUSE:   m_mcause = r.wdata;
      csr_pkg::CSR_ADDR_MTVAL:    m_mtval = r.wdata;
      default: ;
    endcase
  end
  m_minstret = m_minstret + 64'd1;
  return r;
endfunction

`endif

/* tests/csr_unit_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module csr_unit_tb;

  localparam int N_INSN       = 400;
  localparam int RESET_CYCLES = 4;

  logic                clk_i;
  logic                rst_i;
  logic                in_valid_i;
  logic                in_ready_o;
  csr_pkg::xlen_t      in_pc_i;
  csr_pkg::xlen_t      in_insn_i;
  csr_pkg::xlen_t      in_rs1_data_i;
  logic                in_trap_i;
  csr_pkg::cause_t     in_cause_i;
  csr_pkg::xlen_t      in_tval_i;
  logic                out_valid_o;
  logic                out_ready_i;
  csr_pkg::xlen_t      out_pc_o;
  csr_pkg::reg_addr_t  out_rd_addr_o;
  csr_pkg::xlen_t      out_rd_data_o;
  logic                out_rd_we_o;
  csr_pkg::csr_addr_t  out_csr_addr_o;
  csr_pkg::xlen_t      out_csr_rmask_o;
  csr_pkg::xlen_t      out_csr_wmask_o;
  csr_pkg::xlen_t      out_csr_rdata_o;
  csr_pkg::xlen_t      out_csr_wdata_o;
  logic                out_trap_o;
  csr_pkg::cause_t     out_cause_o;
  csr_pkg::xlen_t      out_redirect_pc_o;

  `include "csr_model.svh"

  record_t        exp_q[$];
  record_t        held_rec;
  logic           held = 1'b0;
  logic           next_ready = 1'b0;
  logic [31:0]    rng_state;
  logic [63:0]    cycle_count = '0;
  csr_pkg::xlen_t last_mcycle = '0;
  int             checked = 0;

  // nine implemented addresses, then three that must trap
  csr_pkg::csr_addr_t addr_table [12] = '{csr_pkg::CSR_ADDR_MTVEC,
    csr_pkg::CSR_ADDR_MSCRATCH, csr_pkg::CSR_ADDR_MEPC, csr_pkg::CSR_ADDR_MCAUSE,
    csr_pkg::CSR_ADDR_MTVAL, csr_pkg::CSR_ADDR_MCYCLE, csr_pkg::CSR_ADDR_MCYCLEH,
    csr_pkg::CSR_ADDR_MINSTRET, csr_pkg::CSR_ADDR_MINSTRETH, 12'h300, 12'h7c0, 12'hc00};

  csr_unit dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // same count as mcycle, both start at the end of reset
  always @(posedge clk_i) begin
    if (rst_i)
      cycle_count <= '0;
    else
      cycle_count <= cycle_count + 64'd1;
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input csr_pkg::xlen_t exp,
                            input csr_pkg::xlen_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_cause(input string name, input csr_pkg::cause_t exp,
                             input csr_pkg::cause_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_reg(input string name, input csr_pkg::reg_addr_t exp,
                           input csr_pkg::reg_addr_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_addr(input string name, input csr_pkg::csr_addr_t exp,
                            input csr_pkg::csr_addr_t act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act)
      fail_run($sformatf("Mismatch %s expected %b actual %b", name, exp, act));
  endtask

  task automatic compare_record(input string tag, input record_t e, input record_t a);
    check_word({tag, " pc"}, e.pc, a.pc);
    check_reg({tag, " rd_addr"}, e.rd_addr, a.rd_addr);
    check_word({tag, " rd_data"}, e.rd_data, a.rd_data);
    check_bit({tag, " rd_we"}, e.rd_we, a.rd_we);
    check_addr({tag, " csr_addr"}, e.csr_addr, a.csr_addr);
    check_word({tag, " rmask"}, e.rmask, a.rmask);
    check_word({tag, " wmask"}, e.wmask, a.wmask);
    check_word({tag, " csr_rdata"}, e.rdata, a.rdata);
    check_word({tag, " csr_wdata"}, e.wdata, a.wdata);
    check_bit({tag, " trap"}, e.trap, a.trap);
    check_cause({tag, " cause"}, e.cause, a.cause);
    check_word({tag, " redirect"}, e.redirect, a.redirect);
  endtask

  function automatic record_t sample_output();
    record_t r;
    r          = '0;
    r.pc       = out_pc_o;
    r.rd_addr  = out_rd_addr_o;
    r.rd_data  = out_rd_data_o;
    r.rd_we    = out_rd_we_o;
    r.csr_addr = out_csr_addr_o;
    r.rmask    = out_csr_rmask_o;
    r.wmask    = out_csr_wmask_o;
    r.rdata    = out_csr_rdata_o;
    r.wdata    = out_csr_wdata_o;
    r.trap     = out_trap_o;
    r.cause    = out_cause_o;
    r.redirect = out_redirect_pc_o;
    return r;
  endfunction

  ////////////////////
  // sink
  ////////////////////

  task automatic watch_output();
    record_t act;
    record_t exp;
    act = sample_output();
    if (held) begin
      check_bit($sformatf("record %0d held valid", checked), 1'b1, out_valid_o);
      compare_record($sformatf("record %0d held", checked), held_rec, act);
    end
    held     = out_valid_o && !out_ready_i;
    held_rec = act;
    if (out_valid_o && out_ready_i) begin
      if (exp_q.size() == 0)
        fail_run("a record came out with no accepted instruction behind it");
      exp = exp_q.pop_front();
      // mcycle low can only be checked for order and bound
      if (exp.csr_addr == csr_pkg::CSR_ADDR_MCYCLE) begin
        if (act.rdata <= last_mcycle || act.rdata >= cycle_count[31:0])
          fail_run($sformatf("mcycle read %h out of order, previous %h, cycle %0d",
                             act.rdata, last_mcycle, cycle_count));
        last_mcycle = act.rdata;
        exp.rdata   = act.rdata;
        exp.rd_data = act.rdata;
        exp.wdata   = model_modify(exp.wtype, act.rdata, exp.operand);
      end
      compare_record($sformatf("record %0d", checked), exp, act);
      checked++;
    end
  endtask

  // outputs are read before the edge updates them, ready is drawn here
  always @(posedge clk_i) begin
    if (!rst_i)
      watch_output();
    rng_state  = xorshift32(rng_state);
    next_ready = (rng_state % 10) >= 3;
  end

  always @(negedge clk_i) begin
    out_ready_i = next_ready;
  end

  ////////////////////
  // source
  ////////////////////

  task automatic drive_instructions();
    csr_pkg::xlen_t r;
    csr_pkg::xlen_t d;
    csr_pkg::xlen_t pc;
    logic [4:0]     rd;
    logic [4:0]     rs1;
    logic [3:0]     idx;
    int             i;
    pc = 32'h8000_0000;
    for (i = 0; i < N_INSN; i++) begin
      rng_state = xorshift32(rng_state);
      r         = rng_state;
      rng_state = xorshift32(rng_state);
      d         = rng_state;
      if (r[31:29] == 3'b000) begin
        in_valid_i = 1'b0;
        @(negedge clk_i);
      end
      rd  = (r[3:2] == 2'b00) ? 5'd0 : r[8:4];
      rs1 = (r[10:9] == 2'b00) ? 5'd0 : r[15:11];
      idx = 4'(d % 12);
      // one in eight is a plain alu instruction
      if (r[18:16] == 3'b000)
        in_insn_i = {d[31:7], 7'b0110011};
      else
        in_insn_i = {addr_table[idx], rs1, r[21:19], rd, csr_pkg::OPCODE_SYSTEM};
      in_valid_i    = 1'b1;
      in_pc_i       = pc;
      in_rs1_data_i = d;
      in_trap_i     = (r[25:22] == 4'd0);
      in_cause_i    = r[29:26];
      in_tval_i     = ~d;
      @(posedge clk_i);
      while (!in_ready_o)
        @(posedge clk_i);
      exp_q.push_back(model_retire(pc, in_insn_i, in_rs1_data_i, in_trap_i, in_cause_i,
                                   in_tval_i));
      pc = pc + 32'd4;
      @(negedge clk_i);
    end
    in_valid_i = 1'b0;
  endtask

  initial begin
    rst_i         = 1'b1;
    in_valid_i    = 1'b0;
    in_pc_i       = '0;
    in_insn_i     = '0;
    in_rs1_data_i = '0;
    in_trap_i     = 1'b0;
    in_cause_i    = '0;
    in_tval_i     = '0;
    out_ready_i   = 1'b0;
    rng_state     = 32'd82;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    drive_instructions();
    wait (checked == N_INSN);
    repeat (5) @(negedge clk_i);
    if (exp_q.size() == 0 && !out_valid_o) begin
      $display("test passed");
      $finish;
    end else begin
      fail_run("output stream still busy after the last expected record");
    end
  end

  // watchdog
  initial begin
    repeat (N_INSN * 20 + RESET_CYCLES) @(posedge clk_i);
    fail_run($sformatf("run timed out with %0d records still outstanding",
                       N_INSN - checked));
  end

endmodule

`default_nettype wire

/* csr_unit.f */
+incdir+tests
hdl/csr_pkg.sv
hdl/csr_decode.sv
hdl/csr_regfile.sv
hdl/csr_retire.sv
hdl/csr_unit.sv
tests/csr_unit_tb.sv

/* Makefile */
SIM        := verilator
FILELIST   := csr_unit.f
TB_TOP     := csr_unit_tb
RTL_TOP    := csr_unit
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -Mdir $(OBJ_DIR)

.PHONY: all lint sim clean

all: sim

# static checks on the design top level
lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# build and run, the exit status of the binary is the verdict
sim:
	$(SIM) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP)

clean:
	rm -rf $(OBJ_DIR)
